// File: design/iq_pkg.sv
package iq_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  tag_t;
    typedef logic [3:0]  age_t;

    // saturation value of the per-entry age counter
    localparam age_t AGE_MAX = 4'd15;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // shifts take the low 5 bits of b, slt is a signed compare
    function automatic word_t alu_eval(alu_op_e op, word_t a, word_t b);
        word_t res;
        case (op)
            ALU_ADD: res = a + b;
            ALU_SUB: res = a - b;
            ALU_AND: res = a & b;
            ALU_OR:  res = a | b;
            ALU_XOR: res = a ^ b;
            ALU_SLL: res = a << b[4:0];
            ALU_SRL: res = a >> b[4:0];
            ALU_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: res = '0;
        endcase
        return res;
    endfunction

endpackage

// File: design/iq_issue_if.sv
interface iq_issue_if;

    // one-cycle strobe, only raised when the result register can load
    logic            valid;
    iq_pkg::alu_op_e op;
    iq_pkg::word_t   src0;
    iq_pkg::word_t   src1;
    iq_pkg::tag_t    dest_tag;

    modport sched (
        output valid,
        output op,
        output src0,
        output src1,
        output dest_tag
    );

    modport alu (
        input valid,
        input op,
        input src0,
        input src1,
        input dest_tag
    );

endinterface

// File: design/iq_entry.sv
module iq_entry (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     flush_i,
    input  logic                     write_i,
    input  iq_pkg::alu_op_e          op_i,
    input  iq_pkg::tag_t             dest_tag_i,
    input  logic [1:0]               src_rdy_i,
    input  iq_pkg::tag_t [1:0]       src_tag_i,
    input  iq_pkg::word_t [1:0]      src_data_i,
    input  logic                     cdb_valid_i,
    input  iq_pkg::tag_t             cdb_tag_i,
    input  iq_pkg::word_t            cdb_data_i,
    input  logic                     wk_valid_i,
    input  iq_pkg::tag_t             wk_tag_i,
    input  iq_pkg::word_t            wk_data_i,
    input  logic                     issue_i,
    output logic                     busy_o,
    output logic                     ready_o,
    output iq_pkg::age_t             age_o,
    output iq_pkg::alu_op_e          op_o,
    output iq_pkg::word_t            src0_o,
    output iq_pkg::word_t            src1_o,
    output iq_pkg::tag_t             dest_tag_o
);

    logic                busy_q;
    logic [1:0]          src_rdy_q;
    logic [1:0]          src_rdy_d;
    iq_pkg::word_t [1:0] src_data_q;
    iq_pkg::word_t [1:0] src_data_d;
    iq_pkg::tag_t [1:0]  src_tag_q;
    iq_pkg::age_t        age_q;
    iq_pkg::alu_op_e     op_q;
    iq_pkg::tag_t        dest_tag_q;
    logic [1:0]          waiting;
    logic [1:0]          cdb_hit;
    logic [1:0]          wk_hit;

    // ------------------------------------------------------------------
    // operand capture, also on the dispatch cycle itself
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            waiting[s]    = write_i ? !src_rdy_i[s] : (busy_q && !src_rdy_q[s]);
            cdb_hit[s]    = cdb_valid_i && (cdb_tag_i == (write_i ? src_tag_i[s] : src_tag_q[s]));
            wk_hit[s]     = wk_valid_i && (wk_tag_i == (write_i ? src_tag_i[s] : src_tag_q[s]));
            src_rdy_d[s]  = write_i ? src_rdy_i[s] : src_rdy_q[s];
            src_data_d[s] = write_i ? src_data_i[s] : src_data_q[s];
            if (waiting[s] && cdb_hit[s]) begin
                src_rdy_d[s]  = 1'b1;
                src_data_d[s] = cdb_data_i;
            end else if (waiting[s] && wk_hit[s]) begin
                src_rdy_d[s]  = 1'b1;
                src_data_d[s] = wk_data_i;
            end
        end
    end

    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q    <= 1'b0;
            src_rdy_q <= '0;
            age_q     <= '0;
        end else if (flush_i) begin
            busy_q    <= 1'b0;
            src_rdy_q <= '0;
            age_q     <= '0;
        end else begin
            src_rdy_q <= src_rdy_d;
            if (write_i) begin
                busy_q <= 1'b1;
                age_q  <= '0;
            end else if (issue_i) begin
                busy_q <= 1'b0;
                age_q  <= '0;
            end else if (ready_o && age_q != iq_pkg::AGE_MAX) begin
                age_q <= age_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        src_data_q <= src_data_d;
        if (write_i) begin
            op_q       <= op_i;
            dest_tag_q <= dest_tag_i;
            src_tag_q  <= src_tag_i;
        end
    end

    assign busy_o     = busy_q;
    assign ready_o    = busy_q && (&src_rdy_q);
    assign age_o      = age_q;
    assign op_o       = op_q;
    assign src0_o     = src_data_q[0];
    assign src1_o     = src_data_q[1];
    assign dest_tag_o = dest_tag_q;

endmodule

// File: design/iq_scheduler.sv
module iq_scheduler #(
    parameter int IQ_SIZE = 4
) (
    input  logic                              clk,
    input  logic                              arst_n_i,
    input  logic                              flush_i,
    input  logic                              dispatch_valid_i,
    output logic                              dispatch_ready_o,
    input  logic [IQ_SIZE-1:0]                entry_busy_i,
    input  logic [IQ_SIZE-1:0]                entry_ready_i,
    input  iq_pkg::age_t [IQ_SIZE-1:0]        entry_age_i,
    input  iq_pkg::alu_op_e [IQ_SIZE-1:0]     entry_op_i,
    input  iq_pkg::word_t [IQ_SIZE-1:0]       entry_src0_i,
    input  iq_pkg::word_t [IQ_SIZE-1:0]       entry_src1_i,
    input  iq_pkg::tag_t [IQ_SIZE-1:0]        entry_dest_tag_i,
    input  logic                              out_free_i,
    output logic [IQ_SIZE-1:0]                write_o,
    output logic [IQ_SIZE-1:0]                issue_o,
    iq_issue_if.sched                         issue
);

    localparam int IDX_W = $clog2(IQ_SIZE);

    logic               free_q;
    logic               slot_found;
    logic               sel_found;
    logic [IDX_W-1:0]   sel_idx;
    iq_pkg::age_t       best_age;
    logic [IQ_SIZE-1:0] busy_next;

    // ------------------------------------------------------------------
    // allocation into the lowest free slot
    always_comb begin
        write_o    = '0;
        slot_found = 1'b0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (!entry_busy_i[i] && !slot_found) begin
                write_o[i] = dispatch_valid_i && free_q;
                slot_found = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // oldest ready entry wins and ties go to the lowest index
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        best_age  = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (entry_ready_i[i] && (!sel_found || entry_age_i[i] > best_age)) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
                best_age  = entry_age_i[i];
            end
        end
        issue_o = '0;
        if (sel_found && out_free_i) begin
            issue_o[sel_idx] = 1'b1;
        end
    end

    assign issue.valid    = sel_found && out_free_i;
    assign issue.op       = entry_op_i[sel_idx];
    assign issue.src0     = entry_src0_i[sel_idx];
    assign issue.src1     = entry_src1_i[sel_idx];
    assign issue.dest_tag = entry_dest_tag_i[sel_idx];

    // free flag tracks occupancy after this edge
    assign busy_next = (entry_busy_i & ~issue_o) | write_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            free_q <= 1'b1;
        end else if (flush_i) begin
            free_q <= 1'b1;
        end else begin
            free_q <= !(&busy_next);
        end
    end

    assign dispatch_ready_o = free_q;

endmodule

// File: design/iq_alu_stage.sv
module iq_alu_stage (
    input  logic          clk,
    input  logic          arst_n_i,
    input  logic          flush_i,
    iq_issue_if.alu       issue,
    input  logic          result_ready_i,
    output logic          result_valid_o,
    output iq_pkg::tag_t  result_tag_o,
    output iq_pkg::word_t result_data_o,
    output logic          out_free_o,
    output logic          wk_valid_o,
    output iq_pkg::tag_t  wk_tag_o,
    output iq_pkg::word_t wk_data_o
);

    iq_pkg::word_t alu_res;
    logic          valid_q;
    iq_pkg::tag_t  tag_q;
    iq_pkg::word_t data_q;

    assign alu_res = iq_pkg::alu_eval(issue.op, issue.src0, issue.src1);

    // ------------------------------------------------------------------
    // result register, held while the consumer stalls
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (issue.valid) begin
            valid_q <= 1'b1;
        end else if (result_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            tag_q  <= issue.dest_tag;
            data_q <= alu_res;
        end
    end

    // empty or draining this cycle
    assign out_free_o     = !valid_q || result_ready_i;

    assign result_valid_o = valid_q;
    assign result_tag_o   = tag_q;
    assign result_data_o  = data_q;

    // broadcast on handoff
    assign wk_valid_o = valid_q && result_ready_i;
    assign wk_tag_o   = tag_q;
    assign wk_data_o  = data_q;

endmodule

// File: design/alu_iq.sv
module alu_iq #(
    parameter int IQ_SIZE = 4
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 flush_i,
    input  logic                 dispatch_valid_i,
    output logic                 dispatch_ready_o,
    input  iq_pkg::alu_op_e      dispatch_op_i,
    input  iq_pkg::tag_t         dispatch_dest_tag_i,
    input  logic [1:0]           dispatch_src_rdy_i,
    input  iq_pkg::tag_t [1:0]   dispatch_src_tag_i,
    input  iq_pkg::word_t [1:0]  dispatch_src_data_i,
    input  logic                 cdb_valid_i,
    input  iq_pkg::tag_t         cdb_tag_i,
    input  iq_pkg::word_t        cdb_data_i,
    output logic                 result_valid_o,
    output iq_pkg::tag_t         result_tag_o,
    output iq_pkg::word_t        result_data_o,
    input  logic                 result_ready_i
);

    logic [IQ_SIZE-1:0]              entry_write;
    logic [IQ_SIZE-1:0]              entry_issue;
    logic [IQ_SIZE-1:0]              entry_busy;
    logic [IQ_SIZE-1:0]              entry_ready;
    iq_pkg::age_t [IQ_SIZE-1:0]      entry_age;
    iq_pkg::alu_op_e [IQ_SIZE-1:0]   entry_op;
    iq_pkg::word_t [IQ_SIZE-1:0]     entry_src0;
    iq_pkg::word_t [IQ_SIZE-1:0]     entry_src1;
    iq_pkg::tag_t [IQ_SIZE-1:0]      entry_dest_tag;
    logic                            out_free;
    logic                            wk_valid;
    iq_pkg::tag_t                    wk_tag;
    iq_pkg::word_t                   wk_data;

    iq_issue_if issue_bus ();

    // ------------------------------------------------------------------
    // entry array
    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        iq_entry u_entry (
            .clk         (clk),
            .arst_n_i    (arst_n_i),
            .flush_i     (flush_i),
            .write_i     (entry_write[i]),
            .op_i        (dispatch_op_i),
            .dest_tag_i  (dispatch_dest_tag_i),
            .src_rdy_i   (dispatch_src_rdy_i),
            .src_tag_i   (dispatch_src_tag_i),
            .src_data_i  (dispatch_src_data_i),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .cdb_data_i  (cdb_data_i),
            .wk_valid_i  (wk_valid),
            .wk_tag_i    (wk_tag),
            .wk_data_i   (wk_data),
            .issue_i     (entry_issue[i]),
            .busy_o      (entry_busy[i]),
            .ready_o     (entry_ready[i]),
            .age_o       (entry_age[i]),
            .op_o        (entry_op[i]),
            .src0_o      (entry_src0[i]),
            .src1_o      (entry_src1[i]),
            .dest_tag_o  (entry_dest_tag[i])
        );
    end

    iq_scheduler #(
        .IQ_SIZE (IQ_SIZE)
    ) u_sched (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_ready_o (dispatch_ready_o),
        .entry_busy_i     (entry_busy),
        .entry_ready_i    (entry_ready),
        .entry_age_i      (entry_age),
        .entry_op_i       (entry_op),
        .entry_src0_i     (entry_src0),
        .entry_src1_i     (entry_src1),
        .entry_dest_tag_i (entry_dest_tag),
        .out_free_i       (out_free),
        .write_o          (entry_write),
        .issue_o          (entry_issue),
        .issue            (issue_bus.sched)
    );

    iq_alu_stage u_alu (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .issue          (issue_bus.alu),
        .result_ready_i (result_ready_i),
        .result_valid_o (result_valid_o),
        .result_tag_o   (result_tag_o),
        .result_data_o  (result_data_o),
        .out_free_o     (out_free),
        .wk_valid_o     (wk_valid),
        .wk_tag_o       (wk_tag),
        .wk_data_o      (wk_data)
    );

endmodule

// File: verif/alu_iq_assertions.sv
module alu_iq_assertions (
    input logic          clk,
    input logic          arst_n_i,
    input logic          flush_i,
    input logic          dispatch_ready_o,
    input logic          result_valid_o,
    input logic          result_ready_i,
    input iq_pkg::tag_t  result_tag_o,
    input iq_pkg::word_t result_data_o
);

    int fail_count = 0;

    // ----------------------------------------------------------------------
    // output handshake under back-pressure
    a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        result_valid_o && !result_ready_i && !flush_i |=>
            $stable(result_tag_o) && $stable(result_data_o))
    else begin
        $error("result tag or data changed while stalled");
        fail_count++;
    end

    // a stalled result is neither dropped nor replaced by a new issue
    a_hold_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        result_valid_o && !result_ready_i && !flush_i |=> result_valid_o)
    else begin
        $error("stalled result dropped without a transfer");
        fail_count++;
    end

    // ----------------------------------------------------------------------
    a_flush_clear: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> !result_valid_o && dispatch_ready_o)
    else begin
        $error("queue or result register not empty after flush");
        fail_count++;
    end

endmodule

bind alu_iq alu_iq_assertions u_sva (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .flush_i          (flush_i),
    .dispatch_ready_o (dispatch_ready_o),
    .result_valid_o   (result_valid_o),
    .result_ready_i   (result_ready_i),
    .result_tag_o     (result_tag_o),
    .result_data_o    (result_data_o)
);

// File: verif/tb_alu_iq.sv
module tb_alu_iq;

    localparam int IQ_SIZE = 4;
    localparam int TIMEOUT = 200;

    logic                clk;
    logic                arst_n_i;
    logic                flush_i;
    logic                dispatch_valid_i;
    logic                dispatch_ready_o;
    iq_pkg::alu_op_e     dispatch_op_i;
    iq_pkg::tag_t        dispatch_dest_tag_i;
    logic [1:0]          dispatch_src_rdy_i;
    iq_pkg::tag_t [1:0]  dispatch_src_tag_i;
    iq_pkg::word_t [1:0] dispatch_src_data_i;
    logic                cdb_valid_i;
    iq_pkg::tag_t        cdb_tag_i;
    iq_pkg::word_t       cdb_data_i;
    logic                result_valid_o;
    iq_pkg::tag_t        result_tag_o;
    iq_pkg::word_t       result_data_o;
    logic                result_ready_i;

    // model state indexed by tag
    iq_pkg::word_t exp_val [16];
    logic          inflight [16];
    iq_pkg::tag_t  next_tag = '0;
    iq_pkg::tag_t  got_order [$];
    logic [31:0]   lfsr = 32'h88d1;
    logic          rand_ready = 1'b0;
    logic          saw_full = 1'b0;
    int            errors = 0;
    int            checks = 0;
    int            test_num = 0;
    int            test_base = 0;

    alu_iq #(.IQ_SIZE (IQ_SIZE)) DUT (.*);

    always #2 clk = ~clk;

    // ----------------------------------------------------------------------
    // fibonacci lfsr stepped once per bit
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic iq_pkg::alu_op_e rand_op();
        return iq_pkg::alu_op_e'(3'(rand_bits(3)));
    endfunction

    // expected ALU result
    function automatic iq_pkg::word_t ref_alu(input iq_pkg::alu_op_e op,
                                              input iq_pkg::word_t a, input iq_pkg::word_t b);
        iq_pkg::word_t r;
        case (op)
            iq_pkg::ALU_ADD: r = a + b;
            iq_pkg::ALU_SUB: r = a + ~b + 32'd1;
            iq_pkg::ALU_AND: r = a & b;
            iq_pkg::ALU_OR:  r = a | b;
            iq_pkg::ALU_XOR: r = a ^ b;
            iq_pkg::ALU_SLL: r = a << b[4:0];
            iq_pkg::ALU_SRL: r = a >> b[4:0];
            // with differing signs the negative operand is smaller
            default:         r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
        endcase
        return r;
    endfunction

    function automatic iq_pkg::tag_t alloc_tag();
        iq_pkg::tag_t cand;
        iq_pkg::tag_t t;
        logic         found;
        found = 1'b0;
        t     = '0;
        for (int i = 0; i < 16; i++) begin
            cand = next_tag + 4'(i);
            if (!found && !inflight[cand]) begin
                t     = cand;
                found = 1'b1;
            end
        end
        next_tag = t + 4'd1;
        return t;
    endfunction

    function automatic int count_inflight();
        int n;
        n = 0;
        for (int i = 0; i < 16; i++) begin
            n += int'(inflight[i]);
        end
        return n;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
        if (rand_ready) begin
            result_ready_i = lfsr_step();
        end
    endtask

    task automatic clear_inflight();
        for (int i = 0; i < 16; i++) begin
            inflight[i] = 1'b0;
        end
    endtask

    // ----------------------------------------------------------------------
    // dispatch one instruction whose sources wait on a producer tag or carry a value
    task automatic send(input iq_pkg::alu_op_e op, input logic dep0, input iq_pkg::tag_t p0,
                        input logic dep1, input iq_pkg::tag_t p1, output iq_pkg::tag_t dest);
        logic [1:0]          dep;
        iq_pkg::tag_t [1:0]  ptag;
        iq_pkg::word_t [1:0] val;
        logic                done;
        int                  t;
        ptag[0] = p0;
        ptag[1] = p1;
        dep[0]  = dep0 && inflight[p0];
        dep[1]  = dep1 && inflight[p1];
        val[0]  = dep0 ? exp_val[p0] : rand_bits(32);
        val[1]  = dep1 ? exp_val[p1] : rand_bits(32);
        dest    = alloc_tag();
        exp_val[dest]  = ref_alu(op, val[0], val[1]);
        inflight[dest] = 1'b1;
        dispatch_valid_i    = 1'b1;
        dispatch_op_i       = op;
        dispatch_dest_tag_i = dest;
        dispatch_src_tag_i  = ptag;
        done = 1'b0;
        t    = 0;
        while (!done && t < TIMEOUT) begin
            for (int s = 0; s < 2; s++) begin
                dispatch_src_rdy_i[s]  = !dep[s] || !inflight[ptag[s]];
                // a waiting source carries inverted data as a decoy
                dispatch_src_data_i[s] = dispatch_src_rdy_i[s] ? val[s] : ~val[s];
            end
            done = dispatch_ready_o;
            tick();
            t++;
        end
        dispatch_valid_i = 1'b0;
        if (!done) begin
            $display("dispatch of tag %0d timed out, dispatch_ready_o stayed low", dest);
            errors++;
        end
    endtask

    task automatic reserve_tag(output iq_pkg::tag_t t);
        t = alloc_tag();
        inflight[t] = 1'b1;
        exp_val[t]  = rand_bits(32);
    endtask

    task automatic cdb_pulse(input iq_pkg::tag_t t);
        cdb_valid_i = 1'b1;
        cdb_tag_i   = t;
        cdb_data_i  = exp_val[t];
        inflight[t] = 1'b0;
        tick();
        cdb_valid_i = 1'b0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (count_inflight() != 0 && t < TIMEOUT) begin
            tick();
            t++;
        end
        if (count_inflight() != 0) begin
            $display("timed out waiting for %0d outstanding results", count_inflight());
            errors++;
            clear_inflight();
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, errors - test_base);
        test_base = errors;
    endtask

    // ----------------------------------------------------------------------
    // compare every result handoff against the model
    always @(negedge clk) begin
        if (arst_n_i && result_valid_o && result_ready_i && !flush_i) begin
            if (!inflight[result_tag_o]) begin
                $display("result with tag %0d arrived with no such instruction in flight",
                         result_tag_o);
                errors++;
            end else begin
                check("result_data_o", result_data_o, exp_val[result_tag_o]);
                inflight[result_tag_o] = 1'b0;
            end
            got_order.push_back(result_tag_o);
        end
        if (arst_n_i && !dispatch_ready_o) begin
            saw_full = 1'b1;
        end
    end

    initial begin
        iq_pkg::tag_t p0, p1, p2, p3, tr;
        iq_pkg::tag_t order [IQ_SIZE];
        int           t;
        clk                 = 1'b0;
        arst_n_i            = 1'b0;
        flush_i             = 1'b0;
        dispatch_valid_i    = 1'b0;
        dispatch_op_i       = iq_pkg::ALU_ADD;
        dispatch_dest_tag_i = '0;
        dispatch_src_rdy_i  = '0;
        dispatch_src_tag_i  = '0;
        dispatch_src_data_i = '0;
        cdb_valid_i         = 1'b0;
        cdb_tag_i           = '0;
        cdb_data_i          = '0;
        result_ready_i      = 1'b1;
        clear_inflight();
        repeat (3) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        tick();

        for (int i = 0; i < 8; i++) begin
            send(iq_pkg::alu_op_e'(3'(i)), 1'b0, 4'd0, 1'b0, 4'd0, p0);
        end
        drain();
        end_test("independent ops");

        // chains mixed with independent work so results complete out of order
        for (int i = 0; i < 3; i++) begin
            send(rand_op(), 1'b0, 4'd0, 1'b0, 4'd0, p0);
            send(rand_op(), 1'b1, p0, 1'b0, 4'd0, p1);
            send(rand_op(), 1'b0, 4'd0, 1'b0, 4'd0, p2);
            send(rand_op(), 1'b1, p1, 1'b1, p2, p3);
        end
        drain();
        end_test("dependent chains");

        reserve_tag(tr);
        send(rand_op(), 1'b1, tr, 1'b0, 4'd0, p0);
        send(rand_op(), 1'b1, p0, 1'b1, tr, p1);
        send(rand_op(), 1'b0, 4'd0, 1'b0, 4'd0, p2);
        repeat (4) tick();
        cdb_pulse(tr);
        drain();
        end_test("cdb wakeup");

        // hold the output first so the queue fills
        result_ready_i = 1'b0;
        saw_full       = 1'b0;
        for (int i = 0; i < 5; i++) begin
            send(rand_op(), 1'b0, 4'd0, 1'b0, 4'd0, p0);
        end
        rand_ready = 1'b1;
        p1 = p0;
        for (int i = 0; i < 12; i++) begin
            send(rand_op(), 1'(rand_bits(1)), p0, 1'(rand_bits(1)), p1, p2);
            p1 = p0;
            p0 = p2;
        end
        drain();
        rand_ready     = 1'b0;
        result_ready_i = 1'b1;
        if (!saw_full) begin
            $display("dispatch_ready_o never fell while the queue was full");
            errors++;
        end
        end_test("random back-pressure");

        reserve_tag(tr);
        got_order.delete();
        for (int i = 0; i < IQ_SIZE; i++) begin
            send(rand_op(), 1'b1, tr, 1'b0, 4'd0, order[i]);
        end
        cdb_pulse(tr);
        drain();
        check("result count", 32'(got_order.size()), 32'(IQ_SIZE));
        for (int i = 0; i < IQ_SIZE && i < got_order.size(); i++) begin
            check("result_tag_o", 32'(got_order[i]), 32'(order[i]));
        end
        end_test("oldest first");

        result_ready_i = 1'b0;
        reserve_tag(tr);
        for (int i = 0; i < 3; i++) begin
            send(rand_op(), 1'b0, 4'd0, 1'b0, 4'd0, p0);
        end
        send(rand_op(), 1'b1, tr, 1'b0, 4'd0, p1);
        t = 0;
        while (!result_valid_o && t < TIMEOUT) begin
            tick();
            t++;
        end
        if (!result_valid_o) begin
            $display("no stalled result appeared before the flush");
            errors++;
        end
        flush_i = 1'b1;
        tick();
        flush_i = 1'b0;
        clear_inflight();
        check("result_valid_o", 32'(result_valid_o), 32'd0);
        check("dispatch_ready_o", 32'(dispatch_ready_o), 32'd1);
        result_ready_i = 1'b1;
        repeat (8) tick();
        for (int i = 0; i < 4; i++) begin
            send(rand_op(), 1'b0, 4'd0, 1'b0, 4'd0, p0);
        end
        drain();
        end_test("flush");

        errors += DUT.u_sva.fail_count;
        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: alu_iq.f
design/iq_pkg.sv
design/iq_issue_if.sv
design/iq_entry.sv
design/iq_scheduler.sv
design/iq_alu_stage.sv
design/alu_iq.sv
verif/alu_iq_assertions.sv
verif/tb_alu_iq.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the alu_iq testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_alu_iq -f alu_iq.f -o sim_alu_iq
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_alu_iq +verilator+error+limit+100 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
